//--- dv/led_matrix_checker.sv
// Concurrent checks on the HUB75 panel signals.
// Bound into every matrix_scan instance.
`timescale 1ns/1ps
`default_nettype none

module led_matrix_checker
    import led_matrix_pkg::*;
(
    input logic   clk_root,
    input logic   rst,
    input panel_t panel
);

    int assert_failures = 0;

    // panel must be dark while data moves or latches
    dark_while_shifting: assert property (@(posedge clk_root) disable iff (rst)
        (panel.clk_pixel || panel.latch) |-> panel.oe_n)
    else begin
        assert_failures++;
        $error("oe_n low while clk_pixel or latch is high");
    end

    latch_single_cycle: assert property (@(posedge clk_root) disable iff (rst)
        panel.latch |=> !panel.latch)
    else begin
        assert_failures++;
        $error("latch high for more than one cycle");
    end

    idle_after_reset: assert property (@(posedge clk_root)
        rst |=> (!panel.clk_pixel && !panel.latch && panel.oe_n && panel.row_addr == '0))
    else begin
        assert_failures++;
        $error("panel signals active right after reset");
    end

endmodule

bind matrix_scan led_matrix_checker i_checker (
    .clk_root(clk_root),
    .rst     (rst),
    .panel   (panel)
);

`default_nettype wire

//--- dv/led_matrix_tb.sv
// Directed testbench for the HUB75 driver. Loads rows over UART, then
// watches the shifted panel data, latch order and display times.
`timescale 1ns/1ps
`default_nettype none

module led_matrix_tb
    import led_matrix_pkg::*;
();

    localparam int PASS_LATCHES  = PLANES * SCAN_ROWS;  // latches per full frame
    localparam int LATCH_TIMEOUT =
        2 * MATRIX_DIV * (PANEL_COLS + 4 + (OE_BASE_TICKS << (PLANES - 1)));

    logic   clk_root = 1'b0;
    logic   rst;
    logic   rx;
    panel_t panel;

    logic [31:0] lfsr_state;
    pixel_t      frame_model [PANEL_ROWS][PANEL_COLS];
    rgb_t        rgb_mask_model;
    plane_mask_t plane_mask_model;

    // monitor state, written at negedge and read at posedge
    rgb_t      shift_top [PANEL_COLS];
    rgb_t      shift_bot [PANEL_COLS];
    rgb_t      lat_top   [PANEL_COLS];
    rgb_t      lat_bot   [PANEL_COLS];
    int        col_idx;
    int        lat_cols;
    int        lat_k;
    int        latch_count;
    scan_row_t lat_row;
    logic      clk_pixel_q;

    led_matrix_top i_dut (
        .clk_root(clk_root),
        .rst     (rst),
        .rx      (rx),
        .panel   (panel)
    );

    always #50 clk_root = ~clk_root;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic compare_rgb(input string name, input rgb_t got, input rgb_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic compare_row(input string name, input scan_row_t got, input scan_row_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp)
            stop_with_failure($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic compare_level(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_with_failure($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // r in bits 14:10, g in 9:5, b in 4:0
    function automatic rgb_t expected_rgb(input pixel_t px, input int plane);
        logic [15:0] w;
        logic        lit;
        rgb_t        e;
        w   = px;
        lit = plane_mask_model[plane];
        e.r = w[10 + plane] & rgb_mask_model.r & lit;
        e.g = w[5 + plane] & rgb_mask_model.g & lit;
        e.b = w[plane] & rgb_mask_model.b & lit;
        return e;
    endfunction

    // 8N1, lsb first; called right after a rising edge
    task automatic send_byte(input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx <= frame[i];
            repeat (UART_TICKS_PER_BIT) @(posedge clk_root);
        end
    endtask

    always @(negedge clk_root) begin
        if (rst) begin
            col_idx     = 0;
            latch_count = 0;
            clk_pixel_q = 1'b0;
        end else begin
            if (panel.clk_pixel && !clk_pixel_q) begin
                if (col_idx < PANEL_COLS) begin
                    shift_top[col_idx] = panel.rgb_top;
                    shift_bot[col_idx] = panel.rgb_bottom;
                end
                col_idx++;
            end
            clk_pixel_q = panel.clk_pixel;
            if (panel.latch) begin
                lat_top  = shift_top;
                lat_bot  = shift_bot;
                lat_cols = col_idx;
                lat_row  = panel.row_addr;
                lat_k    = latch_count;
                latch_count++;
                col_idx = 0;
            end
        end
    end

    always @(negedge clk_root) begin
        if (i_dut.i_matrix_scan.i_checker.assert_failures != 0)
            stop_with_failure("a panel timing assertion failed");
    end

    task automatic wait_latch(output int k);
        int start;
        int cycles;
        start  = latch_count;
        cycles = 0;
        while (latch_count == start) begin
            @(posedge clk_root);
            cycles++;
            if (cycles > LATCH_TIMEOUT) stop_with_failure("timed out waiting for a latch pulse");
        end
        k = lat_k;
    endtask

    task automatic wait_pass_end();
        int k;
        int n;
        k = 0;
        n = 0;
        while (n == 0 || k % PASS_LATCHES != PASS_LATCHES - 1) begin
            wait_latch(k);
            n++;
            if (n > PASS_LATCHES) stop_with_failure("no end of a scan pass was seen");
        end
    endtask

    task automatic check_latched_row(input int row, input int plane);
        compare_count("shifted columns", lat_cols, PANEL_COLS);
        compare_row("row_addr", lat_row, scan_row_t'(row));
        for (int c = 0; c < PANEL_COLS; c++) begin
            compare_rgb($sformatf("rgb_top col %0d plane %0d", c, plane),
                        lat_top[c], expected_rgb(frame_model[row][c], plane));
            compare_rgb($sformatf("rgb_bottom col %0d plane %0d", c, plane),
                        lat_bot[c], expected_rgb(frame_model[row + SCAN_ROWS][c], plane));
        end
    endtask

    // one full frame, all planes of the given row address
    task automatic check_row_pass(input int row);
        int k;
        wait_pass_end();
        for (int n = 0; n < PASS_LATCHES; n++) begin
            wait_latch(k);
            if ((k / PLANES) % SCAN_ROWS == row) check_latched_row(row, k % PLANES);
        end
    endtask

    task automatic load_row(input int row);
        logic [31:0] bits;
        logic [15:0] w;
        send_byte(CMD_LOAD_ROW);
        send_byte(8'(row));
        for (int c = 0; c < PANEL_COLS; c++) begin
            bits = random_bits(15);
            w    = {1'b0, bits[14:0]};
            frame_model[row][c] = pixel_t'(w);
            send_byte(w[15:8]);  // high byte first
            send_byte(w[7:0]);
        end
        repeat (2 * UART_TICKS_PER_BIT) @(posedge clk_root);  // last write lands
    endtask

    task automatic test_reset_and_rows();
        int k;
        @(negedge clk_root);
        compare_level("oe_n", panel.oe_n, 1'b1);
        compare_level("latch", panel.latch, 1'b0);
        compare_level("clk_pixel", panel.clk_pixel, 1'b0);
        compare_row("row_addr", panel.row_addr, scan_row_t'(0));
        for (int n = 0; n < 3 * PLANES; n++) begin
            wait_latch(k);
            compare_row("row_addr at latch", lat_row, scan_row_t'((k / PLANES) % SCAN_ROWS));
        end
    endtask

    task automatic test_oe_width();
        int   k;
        int   low_cycles;
        int   cycles;
        logic done;
        for (int n = 0; n < 2 * PLANES; n++) begin
            wait_latch(k);
            low_cycles = 0;
            cycles     = 0;
            done       = 1'b0;
            while (!done) begin
                @(negedge clk_root);
                cycles++;
                if (!panel.oe_n) low_cycles++;
                else if (low_cycles > 0) done = 1'b1;
                if (cycles > LATCH_TIMEOUT) stop_with_failure("display time never ended");
            end
            compare_count($sformatf("oe_n low cycles plane %0d", k % PLANES), low_cycles,
                          OE_BASE_TICKS * (1 << (k % PLANES)) * MATRIX_DIV);
        end
    endtask

    task automatic test_row_load();
        @(posedge clk_root);
        load_row(3);
        load_row(3 + SCAN_ROWS);
        check_row_pass(3);
    endtask

    task automatic test_rgb_enable();
        @(posedge clk_root);
        send_byte(CMD_RGB_ENABLE);
        send_byte(8'h06);  // green and blue on, red off
        rgb_mask_model.r = 1'b0;
        rgb_mask_model.g = 1'b1;
        rgb_mask_model.b = 1'b1;
        check_row_pass(3);
    endtask

    task automatic test_plane_enable();
        @(posedge clk_root);
        send_byte(8'h55);  // not a command, dropped
        send_byte(CMD_RGB_ENABLE);
        send_byte(8'h07);
        send_byte(CMD_PLANE_ENABLE);
        send_byte(8'h0D);  // planes 0, 2 and 3
        rgb_mask_model   = '1;
        plane_mask_model = 5'b01101;
        check_row_pass(3);
    endtask

    initial begin
        rst              = 1'b1;
        rx               = 1'b1;  // line idle
        lfsr_state       = 32'd67457;
        rgb_mask_model   = '1;
        plane_mask_model = '1;
        repeat (3) @(posedge clk_root);
        rst <= 1'b0;
        test_reset_and_rows();
        test_oe_width();
        test_row_load();
        test_rgb_enable();
        test_plane_enable();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/command_decoder.sv
// Byte-stream command parser. Loads pixel rows into the frame RAM
// and holds the channel and bit-plane enable masks.
`timescale 1ns/1ps
`default_nettype none

module command_decoder
    import led_matrix_pkg::*;
(
    input  logic            clk_root,
    input  logic            rst,
    input  logic            byte_valid,
    input  byte             data,
    output logic            wr_en,
    output mem_write_addr_t wr_addr,
    output byte             wr_data,
    output rgb_t            rgb_enable,
    output plane_mask_t     plane_enable
);

    typedef enum logic [1:0] {DEC_IDLE, DEC_ARG, DEC_ROW, DEC_PIXELS} dec_state_t;

    dec_state_t state;
    logic       arg_is_rgb;  // which mask the argument byte goes to
    row_addr_t  row_q;
    logic [6:0] byte_idx;    // 128 bytes per row

    always_ff @(posedge clk_root) begin
        if (rst) begin
            state        <= DEC_IDLE;
            arg_is_rgb   <= 1'b0;
            row_q        <= '0;
            byte_idx     <= '0;
            wr_en        <= 1'b0;
            rgb_enable   <= '1;
            plane_enable <= '1;
        end else begin
            wr_en <= 1'b0;
            if (byte_valid) begin
                case (state)
                    DEC_IDLE: begin
                        case (data)
                            CMD_RGB_ENABLE: begin
                                state      <= DEC_ARG;
                                arg_is_rgb <= 1'b1;
                            end
                            CMD_PLANE_ENABLE: begin
                                state      <= DEC_ARG;
                                arg_is_rgb <= 1'b0;
                            end
                            CMD_LOAD_ROW: state <= DEC_ROW;
                            default: state <= DEC_IDLE;  // unknown byte, ignore
                        endcase
                    end
                    DEC_ARG: begin
                        if (arg_is_rgb) begin
                            rgb_enable.r <= data[0];
                            rgb_enable.g <= data[1];
                            rgb_enable.b <= data[2];
                        end else begin
                            plane_enable <= data[4:0];
                        end
                        state <= DEC_IDLE;
                    end
                    DEC_ROW: begin
                        row_q    <= data[4:0];
                        byte_idx <= '0;
                        state    <= DEC_PIXELS;
                    end
                    default: begin
                        // high byte then low byte, column 0 first
                        wr_en    <= 1'b1;
                        wr_addr  <= {row_q, byte_idx};
                        wr_data  <= data;
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == 7'd127) state <= DEC_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/frame_ram.sv
// Frame store, one 16-bit word per pixel.
// Byte-wide write port from the decoder, registered word read for the fetch.
`timescale 1ns/1ps
`default_nettype none

module frame_ram
    import led_matrix_pkg::*;
(
    input  logic            clk_root,
    input  logic            wr_en,
    input  mem_write_addr_t wr_addr,
    input  byte             wr_data,
    input  mem_read_addr_t  rd_addr,
    output fb_word_t        rd_data
);

    fb_word_t       mem [PANEL_ROWS * PANEL_COLS];
    mem_read_addr_t wr_word;
    logic           wr_lane;

    assign wr_word = wr_addr[11:1];
    assign wr_lane = ~wr_addr[0];  // even byte address is the high byte

    always_ff @(posedge clk_root) begin
        if (wr_en) begin
            mem[wr_word].bytes[wr_lane] <= wr_data;
        end
        rd_data <= mem[rd_addr];  // one cycle read latency
    end

endmodule

`default_nettype wire

//--- logic/framebuffer_fetch.sv
// Reads the top and bottom pixel of one column and reduces each
// to the requested plane's RGB bits. Result 3 cycles after the request.
`timescale 1ns/1ps
`default_nettype none

module framebuffer_fetch
    import led_matrix_pkg::*;
(
    input  logic              clk_root,
    input  logic              rst,
    input  scan_req_t         req,
    input  rgb_t              rgb_enable,
    input  plane_mask_t       plane_enable,
    output mem_read_addr_t    rd_addr,
    input  fb_word_t          rd_data,
    output rgb_t        [1:0] pixel_rgb  // [0] top half, [1] bottom half
);

    plane_t    plane_q;
    scan_row_t row_q;
    col_addr_t col_q;
    logic      bottom_rd;   // top word on rd_data, bottom address out
    logic      bottom_dat;  // bottom word on rd_data
    rgb_t      top_q;

    function automatic rgb_t plane_bits(pixel_t px, plane_t pl, rgb_t en, plane_mask_t pm);
        rgb_t o;
        o.r = px.r[pl] & en.r & pm[pl];
        o.g = px.g[pl] & en.g & pm[pl];
        o.b = px.b[pl] & en.b & pm[pl];
        return o;
    endfunction

    // top row goes straight out with the request, bottom row one cycle later
    assign rd_addr = bottom_rd ? {1'b1, row_q, col_q} : {1'b0, req.row, req.col};

    always_ff @(posedge clk_root) begin
        if (rst) begin
            bottom_rd  <= 1'b0;
            bottom_dat <= 1'b0;
        end else begin
            bottom_rd  <= req.valid;
            bottom_dat <= bottom_rd;
        end
        if (req.valid) begin
            plane_q <= req.plane;
            row_q   <= req.row;
            col_q   <= req.col;
        end
        if (bottom_rd) top_q <= plane_bits(rd_data.px, plane_q, rgb_enable, plane_enable);
        if (bottom_dat) begin
            pixel_rgb[0] <= top_q;
            pixel_rgb[1] <= plane_bits(rd_data.px, plane_q, rgb_enable, plane_enable);
        end
    end

endmodule

`default_nettype wire

//--- logic/led_matrix_pkg.sv
// Shared constants and types for the HUB75 64x32 panel driver.
// Every design file takes these through a wildcard import.
`default_nettype none

package led_matrix_pkg;

    localparam int PANEL_COLS         = 64;
    localparam int PANEL_ROWS         = 32;
    localparam int SCAN_ROWS          = 16;  // 1/16 scan
    localparam int PLANES             = 5;
    localparam int MATRIX_DIV         = 4;   // clk_root cycles per scanner tick
    localparam int OE_BASE_TICKS      = 8;   // display ticks for plane 0
    localparam int UART_TICKS_PER_BIT = 8;

    localparam int DIV_W      = $clog2(MATRIX_DIV);
    localparam int UART_CNT_W = $clog2(UART_TICKS_PER_BIT);
    localparam int OE_CNT_W   = $clog2(OE_BASE_TICKS) + PLANES;

    localparam logic [7:0] CMD_RGB_ENABLE   = 8'h72;  // 'r'
    localparam logic [7:0] CMD_PLANE_ENABLE = 8'h62;  // 'b'
    localparam logic [7:0] CMD_LOAD_ROW     = 8'h4C;  // 'L'

    typedef logic [5:0]  col_addr_t;
    typedef logic [4:0]  row_addr_t;
    typedef logic [3:0]  scan_row_t;
    typedef logic [2:0]  plane_t;
    typedef logic [4:0]  plane_mask_t;
    typedef logic [11:0] mem_write_addr_t;  // {pixel addr, low byte}
    typedef logic [10:0] mem_read_addr_t;   // row * 64 + col

    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } rgb_t;

    typedef struct packed {
        logic       unused;
        logic [4:0] r;
        logic [4:0] g;
        logic [4:0] b;
    } pixel_t;

    // written byte-wise by the decoder, read as a pixel by the fetch
    typedef union packed {
        pixel_t          px;
        logic [1:0][7:0] bytes;  // [1] is the high byte
    } fb_word_t;

    typedef struct packed {
        logic      valid;
        col_addr_t col;
        scan_row_t row;
        plane_t    plane;
    } scan_req_t;

    typedef struct packed {
        rgb_t      rgb_top;
        rgb_t      rgb_bottom;
        scan_row_t row_addr;
        logic      clk_pixel;
        logic      latch;
        logic      oe_n;
    } panel_t;

endpackage

`default_nettype wire

//--- logic/led_matrix_top.sv
// Top level of the HUB75 driver: UART command input, frame RAM and
// panel scan, all on clk_root.
`timescale 1ns/1ps
`default_nettype none

module led_matrix_top
    import led_matrix_pkg::*;
(
    input  logic   clk_root,
    input  logic   rst,
    input  logic   rx,
    output panel_t panel
);

    logic            byte_valid;
    byte             rx_data;
    logic            wr_en;
    mem_write_addr_t wr_addr;
    byte             wr_data;
    rgb_t            rgb_enable;
    plane_mask_t     plane_enable;
    scan_req_t       req;
    mem_read_addr_t  rd_addr;
    fb_word_t        rd_data;
    rgb_t      [1:0] pixel_rgb;  // top, bottom

    uart_rx i_uart_rx (
        .clk_root  (clk_root),
        .rst       (rst),
        .rx        (rx),
        .byte_valid(byte_valid),
        .data      (rx_data)
    );

    command_decoder i_command_decoder (
        .clk_root    (clk_root),
        .rst         (rst),
        .byte_valid  (byte_valid),
        .data        (rx_data),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rgb_enable  (rgb_enable),
        .plane_enable(plane_enable)
    );

    frame_ram i_frame_ram (
        .clk_root(clk_root),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    framebuffer_fetch i_framebuffer_fetch (
        .clk_root    (clk_root),
        .rst         (rst),
        .req         (req),
        .rgb_enable  (rgb_enable),
        .plane_enable(plane_enable),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .pixel_rgb   (pixel_rgb)
    );

    matrix_scan i_matrix_scan (
        .clk_root (clk_root),
        .rst      (rst),
        .req      (req),
        .pixel_rgb(pixel_rgb),
        .panel    (panel)
    );

endmodule

`default_nettype wire

//--- logic/matrix_scan.sv
// HUB75 scan sequencer. Per row and plane it shifts 64 columns, latches,
// then holds oe_n low for a binary-weighted time before a blank tick.
`timescale 1ns/1ps
`default_nettype none

module matrix_scan
    import led_matrix_pkg::*;
(
    input  logic            clk_root,
    input  logic            rst,
    output scan_req_t       req,
    input  rgb_t      [1:0] pixel_rgb,
    output panel_t          panel
);

    typedef enum logic [1:0] {PH_SHIFT, PH_LATCH, PH_DISPLAY, PH_BLANK} phase_t;

    phase_t              phase;
    logic [DIV_W-1:0]    div_cnt;   // position inside the current tick
    logic                tick_end;
    logic                fetch_tick;
    col_addr_t           col_cnt;
    scan_row_t           row_cnt;
    plane_t              plane_cnt;
    logic [OE_CNT_W-1:0] oe_cnt;    // display ticks so far

    assign tick_end = div_cnt == DIV_W'(MATRIX_DIV - 1);

    // fetch runs one tick ahead of the shift, blank prefetches column 0
    assign fetch_tick = phase == PH_BLANK ||
                        (phase == PH_SHIFT && col_cnt != col_addr_t'(PANEL_COLS - 1));

    always_comb begin
        req.valid = fetch_tick && div_cnt == '0;
        req.col   = (phase == PH_BLANK) ? '0 : col_cnt + 1'b1;
        req.row   = row_cnt;
        req.plane = plane_cnt;
    end

    always_ff @(posedge clk_root) begin
        if (rst || tick_end) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_root) begin
        if (rst) begin
            phase      <= PH_BLANK;
            col_cnt    <= '0;
            row_cnt    <= '0;
            plane_cnt  <= '0;
            oe_cnt     <= '0;
            panel      <= '0;
            panel.oe_n <= 1'b1;
        end else begin
            panel.latch <= 1'b0;
            // high for the second half of each shift tick
            panel.clk_pixel <= phase == PH_SHIFT && !tick_end &&
                               div_cnt >= DIV_W'(MATRIX_DIV / 2 - 1);
            if (tick_end) begin
                if (fetch_tick) begin  // result of this tick's request
                    panel.rgb_top    <= pixel_rgb[0];
                    panel.rgb_bottom <= pixel_rgb[1];
                end
                case (phase)
                    PH_SHIFT: begin
                        col_cnt <= col_cnt + 1'b1;
                        if (col_cnt == col_addr_t'(PANEL_COLS - 1)) begin
                            phase          <= PH_LATCH;
                            panel.latch    <= 1'b1;
                            panel.row_addr <= row_cnt;
                        end
                    end
                    PH_LATCH: begin
                        phase      <= PH_DISPLAY;
                        panel.oe_n <= 1'b0;
                        oe_cnt     <= '0;
                    end
                    PH_DISPLAY: begin
                        oe_cnt <= oe_cnt + 1'b1;
                        if (oe_cnt == OE_CNT_W'((OE_BASE_TICKS << plane_cnt) - 1)) begin
                            phase      <= PH_BLANK;
                            panel.oe_n <= 1'b1;
                            // next plane, then next row address
                            if (plane_cnt == plane_t'(PLANES - 1)) begin
                                plane_cnt <= '0;
                                row_cnt   <= row_cnt + 1'b1;
                            end else begin
                                plane_cnt <= plane_cnt + 1'b1;
                            end
                        end
                    end
                    default: begin
                        phase   <= PH_SHIFT;
                        col_cnt <= '0;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/uart_rx.sv
// 8N1 serial receiver for the command stream.
// Emits a one-cycle byte_valid strobe about one bit after the stop bit.
`timescale 1ns/1ps
`default_nettype none

module uart_rx
    import led_matrix_pkg::*;
(
    input  logic clk_root,
    input  logic rst,
    input  logic rx,
    output logic byte_valid,
    output byte  data
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t             state;
    logic [1:0]            rx_sync;   // two-flop synchroniser
    logic [UART_CNT_W-1:0] tick_cnt;
    logic [2:0]            bit_cnt;
    logic [7:0]            shift;     // lsb first
    logic                  hold;      // good byte, strobe pending
    logic [UART_CNT_W-1:0] hold_cnt;
    logic                  bit_mid;
    logic                  bit_end;

    assign bit_mid = tick_cnt == UART_CNT_W'(UART_TICKS_PER_BIT / 2 - 1);
    assign bit_end = tick_cnt == UART_CNT_W'(UART_TICKS_PER_BIT - 1);

    always_ff @(posedge clk_root) begin
        if (rst) begin
            rx_sync <= 2'b11;  // line idles high
        end else begin
            rx_sync <= {rx_sync[0], rx};
        end
    end

    always_ff @(posedge clk_root) begin
        if (rst) begin
            state      <= RX_IDLE;
            tick_cnt   <= '0;
            bit_cnt    <= '0;
            hold       <= 1'b0;
            hold_cnt   <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            tick_cnt   <= tick_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    if (!rx_sync[1]) state <= RX_START;
                end
                RX_START: if (bit_mid) begin
                    // glitch check at the middle of the start bit
                    state    <= rx_sync[1] ? RX_IDLE : RX_DATA;
                    tick_cnt <= '0;
                    bit_cnt  <= '0;
                end
                RX_DATA: if (bit_end) begin
                    shift   <= {rx_sync[1], shift[7:1]};
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) state <= RX_STOP;
                end
                default: if (bit_end) begin
                    state <= RX_IDLE;
                    if (rx_sync[1]) begin  // bad stop bit drops the byte
                        data     <= shift;
                        hold     <= 1'b1;
                        hold_cnt <= '0;
                    end
                end
            endcase
            if (hold) begin
                hold_cnt <= hold_cnt + 1'b1;
                if (hold_cnt == UART_CNT_W'(UART_TICKS_PER_BIT - 1)) begin
                    hold       <= 1'b0;
                    byte_valid <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the HUB75 driver testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module led_matrix_tb -f src.f -o led_matrix_sim \
    > build.log 2>&1 || { cat build.log; echo "BUILD FAILED"; exit 1; }

# error limit raised so the testbench sees a checker failure and reports it
./obj_dir/led_matrix_sim +verilator+error+limit+100 > sim.log 2>&1

grep -q "All tests passed" sim.log \
    && { echo "PASS"; exit 0; } \
    || { tail -n 20 sim.log; echo "FAIL"; exit 1; }

//--- src.f
logic/led_matrix_pkg.sv
logic/uart_rx.sv
logic/command_decoder.sv
logic/frame_ram.sv
logic/framebuffer_fetch.sv
logic/matrix_scan.sv
logic/led_matrix_top.sv
dv/led_matrix_checker.sv
dv/led_matrix_tb.sv
